// File: mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Word width, used for data, addresses and registers
`define MIPS_DATA_W 32

// Width of a general register index
`define MIPS_REG_ADDR_W 5

// Address of the first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Fetching from this address stops the CPU
`define MIPS_HALT_ADDR 32'h0000_0000

// Index of $v0, which is tapped out at the top level
`define MIPS_REG_V0 5'd2

`endif

// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // Function field values for R-type instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    // R-type layout; I-type and J-type reuse the low fields
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

    function automatic logic [15:0] imm_of(instr_t instr);
        return {instr.rd, instr.shamt, instr.funct};
    endfunction

    function automatic logic [25:0] index_of(instr_t instr);
        return {instr.rs, instr.rt, instr.rd, instr.shamt, instr.funct};
    endfunction

endpackage

// File: mips_bus_pkg.sv
`include "mips_params.svh"

package mips_bus_pkg;

    // Sequencer states, one instruction in flight at a time
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

    // Master side of the memory-mapped bus
    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] address;
        logic                    read;
        logic                    write;
        logic [`MIPS_DATA_W-1:0] writedata;
        logic [3:0]              byteenable;
    } bus_req_t;

endpackage

// File: mips_reg_file.sv
`include "mips_params.svh"

module mips_reg_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`MIPS_REG_ADDR_W-1:0] rs_idx,
    input  logic [`MIPS_REG_ADDR_W-1:0] rt_idx,
    input  logic [`MIPS_REG_ADDR_W-1:0] wr_idx,
    input  logic                        wr_en,
    input  logic [`MIPS_DATA_W-1:0]     wr_data,
    output logic [`MIPS_DATA_W-1:0]     rs_val,
    output logic [`MIPS_DATA_W-1:0]     rt_val,
    output logic [`MIPS_DATA_W-1:0]     v0
);

    logic [`MIPS_DATA_W-1:0] regs [0:(1 << `MIPS_REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << `MIPS_REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            // $zero never changes
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational read ports
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    assign v0 = regs[`MIPS_REG_V0];

endmodule

// File: mips_alu.sv
`include "mips_params.svh"

module mips_alu import mips_isa_pkg::*; (
    input  instr_t                  instr,
    input  logic [`MIPS_DATA_W-1:0] rs_val,
    input  logic [`MIPS_DATA_W-1:0] rt_val,
    output logic [`MIPS_DATA_W-1:0] result,
    output logic                    branch_taken
);

    logic [15:0]             imm;
    logic [`MIPS_DATA_W-1:0] simm;
    logic [`MIPS_DATA_W-1:0] zimm;
    logic                    lt_reg_s;
    logic                    lt_reg_u;
    logic                    lt_imm_s;
    logic                    lt_imm_u;

    assign imm  = imm_of(instr);
    assign simm = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign zimm = {{(`MIPS_DATA_W-16){1'b0}}, imm};

    // Compares; SLTIU also uses the sign-extended immediate
    assign lt_reg_s = $signed(rs_val) < $signed(rt_val);
    assign lt_reg_u = rs_val < rt_val;
    assign lt_imm_s = $signed(rs_val) < $signed(simm);
    assign lt_imm_u = rs_val < simm;

    always_comb begin
        result = '0;
        case (instr.opcode)
            OP_RTYPE: begin
                case (instr.funct)
                    FN_ADDU: result = rs_val + rt_val;
                    FN_SUBU: result = rs_val - rt_val;
                    FN_AND:  result = rs_val & rt_val;
                    FN_OR:   result = rs_val | rt_val;
                    FN_XOR:  result = rs_val ^ rt_val;
                    FN_SLT:  result = {{(`MIPS_DATA_W-1){1'b0}}, lt_reg_s};
                    FN_SLTU: result = {{(`MIPS_DATA_W-1){1'b0}}, lt_reg_u};
                    // Shifts act on rt by the shamt field
                    FN_SLL:  result = rt_val << instr.shamt;
                    FN_SRL:  result = rt_val >> instr.shamt;
                    FN_SRA:  result = $unsigned($signed(rt_val) >>> instr.shamt);
                    default: result = '0;
                endcase
            end
            OP_ADDIU: result = rs_val + simm;
            OP_SLTI:  result = {{(`MIPS_DATA_W-1){1'b0}}, lt_imm_s};
            OP_SLTIU: result = {{(`MIPS_DATA_W-1){1'b0}}, lt_imm_u};
            OP_ANDI:  result = rs_val & zimm;
            OP_ORI:   result = rs_val | zimm;
            OP_XORI:  result = rs_val ^ zimm;
            OP_LUI:   result = {imm, 16'h0000};
            default:  result = '0;
        endcase
    end

    // Branch condition for BEQ and BNE
    always_comb begin
        case (instr.opcode)
            OP_BEQ:  branch_taken = (rs_val == rt_val);
            OP_BNE:  branch_taken = (rs_val != rt_val);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: mips_control.sv
`include "mips_params.svh"

module mips_control import mips_isa_pkg::*, mips_bus_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        waitrequest,
    input  logic [`MIPS_DATA_W-1:0]     readdata,
    input  logic [`MIPS_DATA_W-1:0]     rs_val,
    input  logic [`MIPS_DATA_W-1:0]     rt_val,
    input  logic [`MIPS_DATA_W-1:0]     alu_result,
    input  logic                        branch_taken,
    output instr_t                      instr,
    output bus_req_t                    bus,
    output logic                        active,
    output logic                        wr_en,
    output logic [`MIPS_REG_ADDR_W-1:0] wr_idx,
    output logic [`MIPS_DATA_W-1:0]     wr_data
);

    cpu_state_t              state;
    logic                    started;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] pc_next;
    instr_t                  ir;
    logic                    pending;
    logic [`MIPS_DATA_W-1:0] target;
    logic [`MIPS_DATA_W-1:0] jump_target;
    logic [15:0]             imm;
    logic [`MIPS_DATA_W-1:0] simm;
    logic [`MIPS_DATA_W-1:0] mem_addr;
    logic                    fetch_req;
    logic                    fetch_done;
    logic                    is_jr;
    logic                    is_j;
    logic                    is_mem;
    logic                    writes_reg;
    logic                    takes_jump;

    assign instr  = ir;
    assign active = (state != HALTED);

    assign pc_next  = pc + 32'd4;
    assign imm      = imm_of(ir);
    assign simm     = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign mem_addr = rs_val + simm;

    // No request goes out until the first cycle after reset
    assign fetch_req  = started && (pc != `MIPS_HALT_ADDR);
    assign fetch_done = (state == FETCH) && fetch_req && !waitrequest;

    assign is_jr  = (ir.opcode == OP_RTYPE) && (ir.funct == FN_JR);
    assign is_j   = (ir.opcode == OP_J);
    assign is_mem = (ir.opcode == OP_LW) || (ir.opcode == OP_SW);

    // branch_taken is already low for anything but BEQ and BNE
    assign takes_jump = is_j || is_jr || branch_taken;

    always_comb begin
        case (ir.opcode)
            OP_RTYPE: writes_reg = !is_jr;
            OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: writes_reg = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

    // Targets are relative to the delay-slot address
    always_comb begin
        if (is_j) begin
            jump_target = {pc_next[31:28], index_of(ir), 2'b00};
        end else if (is_jr) begin
            jump_target = rs_val;
        end else begin
            jump_target = pc_next + {simm[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            started <= 1'b0;
            pc      <= `MIPS_RESET_VECTOR;
            pending <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                FETCH: begin
                    if (started && pc == `MIPS_HALT_ADDR) begin
                        state <= HALTED;
                    end else if (fetch_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    // A target recorded by the previous instruction applies now
                    pc      <= pending ? target : pc_next;
                    pending <= takes_jump;
                    state   <= is_mem ? MEM_ACCESS : FETCH;
                end
                MEM_ACCESS: begin
                    if (!waitrequest) begin
                        state <= FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= instr_t'(readdata);
        end
        if (state == EXEC && takes_jump) begin
            target <= jump_target;
        end
    end

    always_comb begin
        bus.address    = pc;
        bus.read       = 1'b0;
        bus.write      = 1'b0;
        bus.writedata  = rt_val;
        bus.byteenable = 4'b1111;
        case (state)
            FETCH: bus.read = fetch_req;
            MEM_ACCESS: begin
                bus.address = mem_addr;
                bus.read    = (ir.opcode == OP_LW);
                bus.write   = (ir.opcode == OP_SW);
            end
            default: ;
        endcase
    end

    // Write-back of the ALU result in EXEC or of the loaded word on acceptance
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = ir.rt;
        wr_data = alu_result;
        case (state)
            EXEC: begin
                wr_en = writes_reg;
                if (ir.opcode == OP_RTYPE) begin
                    wr_idx = ir.rd;
                end
            end
            MEM_ACCESS: begin
                wr_en   = (ir.opcode == OP_LW) && !waitrequest;
                wr_data = readdata;
            end
            default: ;
        endcase
    end

endmodule

// File: mips_cpu_bus.sv
`include "mips_params.svh"

module mips_cpu_bus import mips_isa_pkg::*, mips_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    active,
    output logic [`MIPS_DATA_W-1:0] register_v0,
    output logic [`MIPS_DATA_W-1:0] address,
    output logic                    write,
    output logic                    read,
    input  logic                    waitrequest,
    output logic [`MIPS_DATA_W-1:0] writedata,
    output logic [3:0]              byteenable,
    input  logic [`MIPS_DATA_W-1:0] readdata
);

    instr_t                      instr;
    bus_req_t                    bus;
    logic [`MIPS_DATA_W-1:0]     rs_val;
    logic [`MIPS_DATA_W-1:0]     rt_val;
    logic [`MIPS_DATA_W-1:0]     alu_result;
    logic                        branch_taken;
    logic                        wr_en;
    logic [`MIPS_REG_ADDR_W-1:0] wr_idx;
    logic [`MIPS_DATA_W-1:0]     wr_data;

    mips_control control_inst (
        .clk          (clk),
        .reset        (reset),
        .waitrequest  (waitrequest),
        .readdata     (readdata),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .instr        (instr),
        .bus          (bus),
        .active       (active),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data)
    );

    mips_alu alu_inst (
        .instr        (instr),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    mips_reg_file reg_file_inst (
        .clk     (clk),
        .reset   (reset),
        .rs_idx  (instr.rs),
        .rt_idx  (instr.rt),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .v0      (register_v0)
    );

    // Bus request onto the port list
    assign address    = bus.address;
    assign read       = bus.read;
    assign write      = bus.write;
    assign writedata  = bus.writedata;
    assign byteenable = bus.byteenable;

endmodule

// File: mips_cpu_sva.sv
`include "mips_params.svh"

module mips_cpu_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    active,
    input logic                    read,
    input logic                    write,
    input logic                    waitrequest,
    input logic [`MIPS_DATA_W-1:0] address,
    input logic [`MIPS_DATA_W-1:0] writedata
);

    timeunit 1ns;
    timeprecision 1ps;

    // Only one transfer direction at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high in the same cycle");

    // A stalled request holds its address and data
    read_held: assert property (@(posedge clk) disable iff (reset)
        read && waitrequest |=> read && $stable(address))
        else $error("read request changed while waitrequest was high");

    write_held: assert property (@(posedge clk) disable iff (reset)
        write && waitrequest |=> write && $stable(address) && $stable(writedata))
        else $error("write request changed while waitrequest was high");

    // Once halted the CPU stays silent until the next reset
    halted_quiet: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus request issued after the CPU halted");

    halted_stays: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
        else $error("active rose again without a reset");

    reset_quiet: assert property (@(posedge clk)
        reset |-> !read && !write)
        else $error("bus request issued during reset");

endmodule

bind mips_cpu_bus mips_cpu_sva bus_checks (.*);

// File: mips_cpu_tb.sv
`include "mips_params.svh"

module mips_cpu_tb import mips_isa_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] DATA_BASE = 32'h0000_1000;

    logic        clk;
    logic        reset = 1'b1;
    logic        waitrequest = 1'b0;
    logic [31:0] readdata;
    logic        active;
    logic        read;
    logic        write;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] prog [0:255];
    logic [31:0] data_mem [0:255];
    logic [31:0] exp_data [0:255];
    logic [31:0] want_v0;
    string       current_test;
    int          prog_len = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          cycles = 0;
    int          cycle_limit = 16;
    int          stall_left = 0;
    event        results_ready;

    mips_cpu_bus mips_cpu_bus_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    // Memory model with the program region at the reset vector and data low
    always_comb begin
        if (address[31]) begin
            readdata = prog[address[9:2]];
        end else begin
            readdata = data_mem[address[9:2]];
        end
    end

    // Accepts a request, then picks 0 to 3 stall cycles for the next one
    always @(posedge clk) begin
        int n;
        if (reset) begin
            waitrequest <= 1'b0;
            stall_left  <= 0;
            for (int i = 0; i < 256; i++) begin
                data_mem[8'(i)] <= fill_word(DATA_BASE + 32'(i) * 4);
            end
        end else if ((read || write) && !waitrequest) begin
            assert (byteenable == 4'b1111) else begin
                $display("ERROR %0t: %s byteenable is %b on a word transfer",
                         $time, current_test, byteenable);
                errors++;
            end
            if (write && !address[31]) begin
                data_mem[address[9:2]] <= writedata;
            end
            n = int'($urandom % 4);
            stall_left  <= n;
            waitrequest <= (n != 0);
        end else if (read || write) begin
            stall_left  <= stall_left - 1;
            waitrequest <= (stall_left > 1);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the CPU did not halt within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rtype_word(funct_t fn, int rs, int rt, int rd, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] itype_word(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jump_word(int index);
        logic [31:0] dest;
        dest = `MIPS_RESET_VECTOR + 32'(index) * 4;
        return {OP_J, dest[27:2]};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog[8'(i)] = fill_word(`MIPS_RESET_VECTOR + 32'(i) * 4);
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        prog[8'(prog_len)] = w;
        prog_len++;
    endtask

    // JR to $zero with a NOP in the delay slot
    task automatic emit_halt();
        emit(rtype_word(FN_JR, 0, 0, 0, 0));
        emit(32'h0000_0000);
    endtask

    // Folds registers first..last into $v0, alternating ADDU and XOR
    task automatic fold_into_v0(input int first, input int last);
        emit(rtype_word(FN_ADDU, first, 0, 2, 0));
        for (int k = first + 1; k <= last; k++) begin
            emit(rtype_word((k % 2) ? FN_XOR : FN_ADDU, 2, k, 2, 0));
        end
    endtask

    // Interprets the program from the instruction-set rules
    function automatic logic [31:0] reference_v0();
        logic [31:0] r [0:31];
        logic [31:0] pc, target, jt, w, a, b, simm, zimm, res, ea;
        logic [4:0]  dst;
        logic        pending, takes, wb;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[5'(i)] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            exp_data[8'(i)] = fill_word(DATA_BASE + 32'(i) * 4);
        end
        pc = `MIPS_RESET_VECTOR;
        target = '0;
        pending = 1'b0;
        steps = 0;
        while (pc != `MIPS_HALT_ADDR && steps < 1000) begin
            w = prog[pc[9:2]];
            a = r[w[25:21]];
            b = r[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            zimm = {16'h0000, w[15:0]};
            jt = pc + 32'd4 + {simm[29:0], 2'b00};
            dst = w[20:16];
            res = '0;
            wb = 1'b1;
            takes = 1'b0;
            ea = a + simm;
            case (w[31:26])
                OP_RTYPE: begin
                    dst = w[15:11];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        FN_SLTU: res = {31'd0, a < b};
                        FN_SLL:  res = b << w[10:6];
                        FN_SRL:  res = b >> w[10:6];
                        FN_SRA:  res = $unsigned($signed(b) >>> w[10:6]);
                        FN_JR: begin
                            wb = 1'b0;
                            takes = 1'b1;
                            jt = a;
                        end
                        default: wb = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + simm;
                OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
                OP_SLTIU: res = {31'd0, a < simm};
                OP_ANDI:  res = a & zimm;
                OP_ORI:   res = a | zimm;
                OP_XORI:  res = a ^ zimm;
                OP_LUI:   res = {w[15:0], 16'h0000};
                OP_LW:    res = exp_data[ea[9:2]];
                OP_BEQ: begin
                    wb = 1'b0;
                    takes = (a == b);
                end
                OP_BNE: begin
                    wb = 1'b0;
                    takes = (a != b);
                end
                OP_J: begin
                    wb = 1'b0;
                    takes = 1'b1;
                    jt = {pc[31:28], w[25:0], 2'b00};
                end
                OP_SW: begin
                    wb = 1'b0;
                    exp_data[ea[9:2]] = b;
                end
                default: wb = 1'b0;
            endcase
            if (wb && dst != 5'd0) begin
                r[dst] = res;
            end
            // A target recorded last step redirects this one
            pc = pending ? target : pc + 32'd4;
            if (takes) begin
                target = jt;
            end
            pending = takes;
            steps++;
        end
        return r[`MIPS_REG_V0];
    endfunction

    initial begin
        forever begin
            @(results_ready);
            assert (register_v0 === want_v0) else begin
                $display("ERROR %0t: %s v0 is %h, expected %h",
                         $time, current_test, register_v0, want_v0);
                errors++;
            end
            for (int i = 0; i < 256; i++) begin
                assert (data_mem[8'(i)] === exp_data[8'(i)]) else begin
                    $display("ERROR %0t: %s data word %0d is %h, expected %h",
                             $time, current_test, i, data_mem[8'(i)], exp_data[8'(i)]);
                    errors++;
                end
            end
            $display("%s: %s", current_test, (errors == errors_at_start) ? "ok" : "FAILED");
            tests_run++;
        end
    end

    task automatic run_program(input string name);
        int done_before;
        current_test = name;
        errors_at_start = errors;
        want_v0 = reference_v0();
        cycle_limit = cycle_limit + 2 * (prog_len * 3 * 4 + 3 + 8);
        if (!reset) begin
            @(posedge clk);
            reset <= 1'b1;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (!(read || write)) @(negedge clk);
        assert (read && !write && address == `MIPS_RESET_VECTOR) else begin
            $display("ERROR %0t: %s first request is not a read at the reset vector",
                     $time, name);
            errors++;
        end
        while (active) @(negedge clk);
        // Quiet window after the halt
        repeat (8) begin
            @(negedge clk);
            assert (!read && !write && !active) else begin
                $display("ERROR %0t: %s bus activity after halt", $time, name);
                errors++;
            end
        end
        done_before = tests_run;
        -> results_ready;
        wait (tests_run == done_before + 1);
    endtask

    initial begin
        void'($urandom(32'he289_c986));

        clear_program();
        emit(itype_word(OP_LUI, 0, 8, 'h8000));
        emit(itype_word(OP_ORI, 8, 8, 'h1234));
        emit(itype_word(OP_LUI, 0, 9, 'h0001));
        emit(itype_word(OP_ORI, 9, 9, 'hF00F));
        emit(rtype_word(FN_ADDU, 8, 9, 10, 0));
        emit(rtype_word(FN_SUBU, 9, 8, 11, 0));
        emit(rtype_word(FN_AND, 8, 9, 12, 0));
        emit(rtype_word(FN_OR, 8, 9, 13, 0));
        emit(rtype_word(FN_XOR, 8, 9, 14, 0));
        emit(rtype_word(FN_SLT, 8, 9, 15, 0));
        emit(rtype_word(FN_SLTU, 8, 9, 16, 0));
        emit(rtype_word(FN_SLL, 0, 9, 17, 4));
        emit(rtype_word(FN_SRL, 0, 8, 18, 3));
        emit(rtype_word(FN_SRA, 0, 8, 19, 3));
        fold_into_v0(10, 19);
        emit_halt();
        run_program("rtype_alu");

        clear_program();
        emit(itype_word(OP_ADDIU, 0, 8, -5));
        emit(itype_word(OP_ANDI, 8, 9, 'hFFF0));
        emit(itype_word(OP_ORI, 0, 10, 'h8001));
        emit(itype_word(OP_XORI, 8, 11, 'h8000));
        emit(itype_word(OP_SLTI, 8, 12, -3));
        emit(itype_word(OP_SLTIU, 0, 13, -1));
        emit(itype_word(OP_SLTI, 10, 14, -1));
        emit(itype_word(OP_SLTIU, 11, 15, -6));
        emit(itype_word(OP_ADDIU, 10, 16, -'h8000));
        fold_into_v0(8, 16);
        emit_halt();
        run_program("immediates");

        clear_program();
        emit(itype_word(OP_ORI, 0, 8, 'h1000));
        emit(itype_word(OP_ADDIU, 0, 9, 'h1234));
        emit(itype_word(OP_SW, 8, 9, 0));
        emit(itype_word(OP_LUI, 0, 10, 'hDEAD));
        emit(itype_word(OP_ORI, 10, 10, 'hBEEF));
        emit(itype_word(OP_SW, 8, 10, 4));
        emit(itype_word(OP_SW, 8, 8, 8));
        emit(itype_word(OP_LW, 8, 11, 4));
        emit(itype_word(OP_LW, 8, 12, 0));
        emit(itype_word(OP_LW, 8, 13, 8));
        emit(itype_word(OP_LW, 8, 14, 16));
        fold_into_v0(11, 14);
        emit(itype_word(OP_SW, 8, 2, 12));
        emit_halt();
        run_program("memory");

        clear_program();
        emit(itype_word(OP_ADDIU, 0, 2, 0));
        emit(itype_word(OP_BEQ, 0, 0, 2));
        emit(itype_word(OP_ADDIU, 2, 2, 'h1));
        emit(itype_word(OP_ADDIU, 2, 2, 'h100));
        emit(itype_word(OP_BNE, 0, 0, 5));
        emit(itype_word(OP_ADDIU, 2, 2, 'h2));
        emit(itype_word(OP_ADDIU, 2, 2, 'h4));
        emit(itype_word(OP_BNE, 2, 0, 2));
        emit(itype_word(OP_ADDIU, 2, 2, 'h8));
        emit(itype_word(OP_ADDIU, 2, 2, 'h200));
        emit(jump_word(13));
        emit(itype_word(OP_ADDIU, 2, 2, 'h20));
        emit(itype_word(OP_ADDIU, 2, 2, 'h400));
        emit(itype_word(OP_BEQ, 2, 0, 3));
        emit(itype_word(OP_ADDIU, 2, 2, 'h40));
        emit(itype_word(OP_ADDIU, 2, 2, -3));
        emit_halt();
        run_program("branches");

        clear_program();
        emit(itype_word(OP_ORI, 0, 9, 0));
        emit(itype_word(OP_ADDIU, 0, 2, 7));
        emit(rtype_word(FN_JR, 9, 0, 0, 0));
        emit(itype_word(OP_ADDIU, 2, 2, 5));
        emit(itype_word(OP_ADDIU, 2, 2, 100));
        emit_halt();
        run_program("halt");

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
mips_isa_pkg.sv
mips_bus_pkg.sv
mips_reg_file.sv
mips_alu.sv
mips_control.sv
mips_cpu_bus.sv
mips_cpu_sva.sv
mips_cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module mips_cpu_tb \
    -o mips_cpu_sim

./obj_dir/mips_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    exit 0
fi
exit 1
